// File: all.f
+incdir+hdl
hdl/tile_gfx_pkg.sv
hdl/display_timing.sv
hdl/main_registers.sv
hdl/dual_port_ram.sv
hdl/mpu_bus_decoder.sv
hdl/tile_renderer.sv
hdl/tile_gfx_top.sv
test/tile_gfx_assertions.sv
test/tile_gfx_tb.sv

// File: Makefile
.PHONY: sim clean

# Builds and runs the testbench; passes only if the pass line is printed
sim:
	verilator --binary --assert -f all.f --top-module tile_gfx_tb -o tile_gfx_sim
	out=$$(./obj_dir/tile_gfx_sim); echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

// File: test/tile_gfx_tb.sv
// Render checks need about four frames of 4480 cycles; every RAM word is written before a frame is compared
`include "tile_gfx_consts.svh"

module tile_gfx_tb import tile_gfx_pkg::*; ();

  localparam int FRAME_CYCLES = (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK) *
                                (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);
  localparam int FRAME_PIXELS = `H_ACTIVE * `V_ACTIVE;
  localparam int WRAP         = `MAP_COLS * `TILE_SIZE;           // Scrolled positions wrap here
  localparam int TILE_WORDS   = `TILE_SIZE * `TILE_SIZE / 2;
  localparam int NUM_TILES    = `VRAM_LENGTH / TILE_WORDS;

  typedef enum logic [1:0] {op_write, op_read, op_vblank, op_frame} op_e;

  typedef struct {
    op_e       op;
    int        test;
    mpu_addr_t addr;
    mpu_data_t data;
    logic [1:0] be;
    mpu_data_t expected;
  } row_t;

  logic       clk;
  logic       rst;
  logic       mpu_en;
  logic       mpu_rd;
  logic       mpu_wr;
  logic [1:0] mpu_be;
  mpu_addr_t  mpu_addr;
  mpu_data_t  mpu_data_in;
  mpu_data_t  mpu_data_out;
  logic       vga_hsync;
  logic       vga_vsync;
  logic       vga_de;
  rgb_t       vga_rgb;

  row_t rows[$];

  // Shadow copies of everything the bus has written
  mpu_data_t  shadow_regs [`NUM_MAIN_REGS];
  mpu_data_t  shadow_map [`MAP_LENGTH];
  mpu_data_t  shadow_vram [`VRAM_LENGTH];
  logic [15:0] shadow_pal_rg [`PAL_LENGTH / 2];
  logic [7:0]  shadow_pal_b [`PAL_LENGTH / 2];

  int pass_count = 0;
  int fail_count = 0;
  int test_fails = 0;
  int cycle_count = 0;
  int cycle_limit = 1000000;   // Replaced once the table is built

  tile_gfx_top dut (
    .clk, .rst, .mpu_en, .mpu_rd, .mpu_wr, .mpu_be, .mpu_addr, .mpu_data_in,
    .mpu_data_out, .vga_hsync, .vga_vsync, .vga_de, .vga_rgb
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  function automatic mpu_data_t merge_bytes(input mpu_data_t old, input mpu_data_t data,
                                            input logic [1:0] be);
    mpu_data_t r;
    r = old;
    if (be[0])
      r[7:0] = data[7:0];
    if (be[1])
      r[15:8] = data[15:8];
    return r;
  endfunction

  // Bus write as seen from the memory map
  task automatic update_shadow(input mpu_addr_t addr, input mpu_data_t data,
                               input logic [1:0] be);
    int a;
    int idx;
    a = int'(addr);
    if (a < `REG_BASE + `NUM_MAIN_REGS) begin
      shadow_regs[a - `REG_BASE] = merge_bytes(shadow_regs[a - `REG_BASE], data, be);
    end else if (a >= `PAL_BASE && a < `PAL_BASE + `PAL_LENGTH) begin
      idx = (a - `PAL_BASE) / 2;
      if ((a - `PAL_BASE) % 2 == 0)
        shadow_pal_rg[idx] = merge_bytes(shadow_pal_rg[idx], data, be);
      else if (be[0])
        shadow_pal_b[idx] = data[7:0];   // Odd word keeps only blue
    end else if (a >= `MAP_BASE && a < `MAP_BASE + `MAP_LENGTH) begin
      shadow_map[a - `MAP_BASE] = merge_bytes(shadow_map[a - `MAP_BASE], data, be);
    end else if (a >= `VRAM_BASE && a < `VRAM_BASE + `VRAM_LENGTH) begin
      shadow_vram[a - `VRAM_BASE] = merge_bytes(shadow_vram[a - `VRAM_BASE], data, be);
    end
  endtask

  // Pixel at screen position (x, y) from the shadow state
  function automatic rgb_t expected_rgb(input int x, input int y);
    int        sx;
    int        sy;
    int        tile;
    mpu_data_t entry;
    mpu_data_t word;
    logic [7:0] pix;
    if (!shadow_regs[`REG_CTRL][0])
      return '0;
    sx = (x + int'(shadow_regs[`REG_SCROLL_X][`HCOUNT_WIDTH-1:0])) % WRAP;
    sy = (y + int'(shadow_regs[`REG_SCROLL_Y][`VCOUNT_WIDTH-1:0])) % WRAP;
    entry = shadow_map[(sy / `TILE_SIZE) * `MAP_COLS + sx / `TILE_SIZE];
    if (entry == 16'hFFFF) begin
      pix = shadow_regs[`REG_BG_INDEX][7:0];
    end else begin
      tile = int'(entry) % NUM_TILES;
      word = shadow_vram[tile * TILE_WORDS + (sy % `TILE_SIZE) * (`TILE_SIZE / 2) +
                         (sx % `TILE_SIZE) / 2];
      pix = (sx % 2 == 1) ? word[15:8] : word[7:0];   // Left pixel in the low byte
    end
    return {shadow_pal_rg[pix][7:2], shadow_pal_rg[pix][15:10], shadow_pal_b[pix][7:2]};
  endfunction

  task automatic check_data(input string name, input mpu_data_t expected,
                            input mpu_data_t actual);
    if (actual === expected) begin
      pass_count++;
    end else begin
      fail_count++;
      test_fails++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
    if (actual === expected) begin
      pass_count++;
    end else begin
      fail_count++;
      test_fails++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic release_bus();
    mpu_en      = 1'b0;
    mpu_rd      = 1'b0;
    mpu_wr      = 1'b0;
    mpu_be      = 2'b00;
    mpu_addr    = '0;
    mpu_data_in = '0;
  endtask

  task automatic write_word(input mpu_addr_t addr, input mpu_data_t data, input logic [1:0] be);
    mpu_en      = 1'b1;
    mpu_wr      = 1'b1;
    mpu_addr    = addr;
    mpu_data_in = data;
    mpu_be      = be;
    @(negedge clk);
    release_bus();
    update_shadow(addr, data, be);
  endtask

  // Data shows up after the second edge
  task automatic read_word(input mpu_addr_t addr, output mpu_data_t data);
    mpu_en   = 1'b1;
    mpu_rd   = 1'b1;
    mpu_addr = addr;
    mpu_be   = 2'b11;
    @(negedge clk);
    release_bus();
    @(negedge clk);
    data = mpu_data_out;
  endtask

  // Counts vga_de cycles from the fall of vsync to its next rise
  task automatic verify_frame();
    int count;
    int x;
    int y;
    while (!vga_vsync)
      @(negedge clk);
    while (vga_vsync)
      @(negedge clk);
    count = 0;
    while (!vga_vsync) begin
      if (vga_de) begin
        if (count < FRAME_PIXELS) begin
          x = count % `H_ACTIVE;
          y = count / `H_ACTIVE;
          check_rgb($sformatf("vga_rgb at (%0d,%0d)", x, y), expected_rgb(x, y), vga_rgb);
        end
        count++;
      end
      @(negedge clk);
    end
    if (count != FRAME_PIXELS) begin
      $display("Frame check: vga_de was high for %0d cycles instead of %0d", count,
               FRAME_PIXELS);
      fail_count++;
      test_fails++;
    end
  endtask

  task automatic add_row(input op_e op, input int test, input mpu_addr_t addr,
                         input mpu_data_t data, input logic [1:0] be, input mpu_data_t expected);
    row_t r;
    r.op       = op;
    r.test     = test;
    r.addr     = addr;
    r.data     = data;
    r.be       = be;
    r.expected = expected;
    rows.push_back(r);
  endtask

  task automatic build_table();
    mpu_addr_t addr;
    mpu_data_t data;
    // Test 1 covers the register bank with partial lanes and unmapped addresses
    add_row(op_write, 1, 16'h0000, 16'h1234, 2'b11, '0);
    add_row(op_write, 1, 16'h0001, 16'h5678, 2'b11, '0);
    add_row(op_write, 1, 16'h0002, 16'h9abc, 2'b11, '0);
    add_row(op_write, 1, 16'h0003, 16'hdef0, 2'b11, '0);
    add_row(op_write, 1, 16'h0001, 16'hffff, 2'b01, '0);  // Low byte only
    add_row(op_write, 1, 16'h0002, 16'h0000, 2'b10, '0);  // High byte only
    add_row(op_write, 1, 16'h0003, 16'haaaa, 2'b00, '0);
    add_row(op_write, 1, 16'h0004, 16'hbeef, 2'b11, '0);  // Unmapped and dropped
    add_row(op_read, 1, 16'h0000, '0, 2'b11, 16'h1234);
    add_row(op_read, 1, 16'h0001, '0, 2'b11, 16'h56ff);
    add_row(op_read, 1, 16'h0002, '0, 2'b11, 16'h00bc);
    add_row(op_read, 1, 16'h0003, '0, 2'b11, 16'hdef0);
    add_row(op_read, 1, 16'h0004, '0, 2'b11, 16'h0000);
    add_row(op_read, 1, 16'h00ff, '0, 2'b11, 16'h0000);
    add_row(op_read, 1, 16'h0300, '0, 2'b11, 16'h0000);
    add_row(op_read, 1, 16'h2000, '0, 2'b11, 16'h0000);
    add_row(op_read, 1, 16'hffff, '0, 2'b11, 16'h0000);
    // Test 2 covers the palette lanes
    add_row(op_write, 2, 16'h010a, 16'h3fc4, 2'b11, '0);
    add_row(op_write, 2, 16'h010b, 16'h7e91, 2'b11, '0);
    add_row(op_read, 2, 16'h010a, '0, 2'b11, 16'h3fc4);
    add_row(op_read, 2, 16'h010b, '0, 2'b11, 16'h0091);
    add_row(op_write, 2, 16'h010a, 16'h55aa, 2'b10, '0);
    add_row(op_write, 2, 16'h010b, 16'h1122, 2'b10, '0);  // Blue only has the low lane
    add_row(op_read, 2, 16'h010a, '0, 2'b11, 16'h55c4);
    add_row(op_read, 2, 16'h010b, '0, 2'b11, 16'h0091);
    add_row(op_write, 2, 16'h02ff, 16'hff3c, 2'b11, '0);
    add_row(op_read, 2, 16'h02ff, '0, 2'b11, 16'h003c);
    // Test 3 reads back random map and VRAM words
    for (int i = 0; i < 16; i++) begin
      addr = mpu_addr_t'(`MAP_BASE + $urandom % `MAP_LENGTH);
      data = mpu_data_t'($urandom);
      add_row(op_write, 3, addr, data, 2'b11, '0);
      add_row(op_read, 3, addr, '0, 2'b11, data);
      addr = mpu_addr_t'(`VRAM_BASE + $urandom % `VRAM_LENGTH);
      data = mpu_data_t'($urandom);
      add_row(op_write, 3, addr, data, 2'b11, '0);
      add_row(op_read, 3, addr, '0, 2'b11, data);
    end
    // Test 4 fills every RAM word and renders one unscrolled frame
    for (int i = 0; i < `MAP_LENGTH; i++) begin
      data = ($urandom % 6 == 0) ? 16'hFFFF : mpu_data_t'($urandom % NUM_TILES);
      add_row(op_write, 4, mpu_addr_t'(`MAP_BASE + i), data, 2'b11, '0);
    end
    for (int i = 0; i < `VRAM_LENGTH; i++)
      add_row(op_write, 4, mpu_addr_t'(`VRAM_BASE + i), mpu_data_t'($urandom), 2'b11, '0);
    for (int i = 0; i < `PAL_LENGTH; i++)
      add_row(op_write, 4, mpu_addr_t'(`PAL_BASE + i), mpu_data_t'($urandom), 2'b11, '0);
    add_row(op_write, 4, mpu_addr_t'(`REG_BG_INDEX), 16'h00a7, 2'b11, '0);
    add_row(op_write, 4, mpu_addr_t'(`REG_SCROLL_X), 16'h0000, 2'b11, '0);
    add_row(op_write, 4, mpu_addr_t'(`REG_SCROLL_Y), 16'h0000, 2'b11, '0);
    add_row(op_write, 4, mpu_addr_t'(`REG_CTRL), 16'h0001, 2'b11, '0);
    add_row(op_frame, 4, '0, '0, 2'b00, '0);
    // Test 5 sets both scrolls in vertical blanking so both axes wrap
    add_row(op_vblank, 5, '0, '0, 2'b00, '0);
    add_row(op_write, 5, mpu_addr_t'(`REG_SCROLL_X), 16'hff4d, 2'b11, '0);
    add_row(op_write, 5, mpu_addr_t'(`REG_SCROLL_Y), 16'h0065, 2'b11, '0);
    add_row(op_frame, 5, '0, '0, 2'b00, '0);
    // Test 6 clears the display enable and sets the other control bits
    add_row(op_vblank, 6, '0, '0, 2'b00, '0);
    add_row(op_write, 6, mpu_addr_t'(`REG_CTRL), 16'hfffe, 2'b11, '0);
    add_row(op_frame, 6, '0, '0, 2'b00, '0);
  endtask

  task automatic apply_row(input row_t r);
    mpu_data_t got;
    case (r.op)
      op_write: write_word(r.addr, r.data, r.be);
      op_read: begin
        read_word(r.addr, got);
        check_data($sformatf("mpu_data_out (addr %h)", r.addr), r.expected, got);
      end
      op_vblank: begin
        while (!vga_vsync)
          @(negedge clk);
      end
      default: verify_frame();
    endcase
  endtask

  function automatic string test_name(input int id);
    case (id)
      1: return "register access";
      2: return "palette lanes";
      3: return "map and VRAM read-back";
      4: return "rendered frame";
      5: return "scrolled frame";
      default: return "display disable";
    endcase
  endfunction

  task automatic report_test(input int id);
    $display("Test %0d, %s: %s", id, test_name(id), (test_fails == 0) ? "passed" : "FAILED");
  endtask

  initial begin
    int current;
    clk = 1'b0;
    rst = 1'b1;
    release_bus();
    void'($urandom(32'hab6a_9a15));
    for (int i = 0; i < `NUM_MAIN_REGS; i++)
      shadow_regs[i] = '0;     // Registers clear on reset
    build_table();
    cycle_limit = 4 * FRAME_CYCLES + 4 * rows.size() + 100;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    current = rows[0].test;
    foreach (rows[i]) begin
      if (rows[i].test != current) begin
        report_test(current);
        current = rows[i].test;
        test_fails = 0;
      end
      apply_row(rows[i]);
    end
    report_test(current);
    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: test/tile_gfx_assertions.sv
// Checks run only after reset is released; read data may be nonzero only two edges after a read
`include "tile_gfx_consts.svh"

module tile_gfx_assertions import tile_gfx_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      mpu_en,
  input logic      mpu_rd,
  input mpu_data_t mpu_data_out,
  input logic      vga_hsync,
  input logic      vga_vsync,
  input logic      vga_de,
  input rgb_t      vga_rgb
);

  int hs_len;   // Cycles of hsync seen so far

  always_ff @(posedge clk) begin
    if (rst)
      hs_len <= 0;
    else
      hs_len <= vga_hsync ? hs_len + 1 : 0;
  end

  rgb_blanked: assert property (@(posedge clk) disable iff (rst) !vga_de |-> vga_rgb == '0)
    else $error("vga_rgb is nonzero while vga_de is low");

  de_outside_sync: assert property (@(posedge clk) disable iff (rst)
    !(vga_de && (vga_hsync || vga_vsync)))
    else $error("vga_de is high during a sync pulse");

  idle_read_data: assert property (@(posedge clk) disable iff (rst)
    !$past(mpu_en && mpu_rd, 2) |-> mpu_data_out == '0)
    else $error("mpu_data_out is nonzero without a read");

  hsync_width: assert property (@(posedge clk) disable iff (rst)
    $fell(vga_hsync) |-> hs_len == `H_SYNC)
    else $error("hsync pulse is %0d cycles long", hs_len);

endmodule

bind tile_gfx_top tile_gfx_assertions protocol_checks (.*);

// File: hdl/tile_gfx_top.sv
// Bus accesses take one cycle with no wait states; read data arrives one cycle after the access edge
`include "tile_gfx_consts.svh"

module tile_gfx_top import tile_gfx_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       mpu_en,
  input  logic       mpu_rd,
  input  logic       mpu_wr,
  input  logic [1:0] mpu_be,
  input  mpu_addr_t  mpu_addr,
  input  mpu_data_t  mpu_data_in,
  output mpu_data_t  mpu_data_out,
  output logic       vga_hsync,
  output logic       vga_vsync,
  output logic       vga_de,
  output rgb_t       vga_rgb
);

  // Host side strobes and data
  logic                        reg_wr;
  logic                        reg_rd;
  logic [`REG_ADDR_WIDTH-1:0]  reg_addr;
  logic [1:0]                  reg_be;
  mpu_data_t                   reg_rdata;
  logic                        pal_wr;
  logic                        pal_rd;
  logic [`PAL_ADDR_WIDTH-1:0]  pal_addr;
  logic [`PAL_BYTES-1:0]       pal_be;
  logic [`PAL_BYTES*8-1:0]     pal_wdata;
  logic [`PAL_BYTES*8-1:0]     pal_rdata;
  logic                        map_wr;
  logic                        map_rd;
  logic [`MAP_ADDR_WIDTH-1:0]  map_addr;
  logic [1:0]                  map_be;
  mpu_data_t                   map_rdata;
  logic                        vram_wr;
  logic                        vram_rd;
  logic [`VRAM_ADDR_WIDTH-1:0] vram_addr;
  logic [1:0]                  vram_be;
  mpu_data_t                   vram_rdata;

  // Control fields
  logic                        display_en;
  logic [`HCOUNT_WIDTH-1:0]    scroll_x;
  logic [`VCOUNT_WIDTH-1:0]    scroll_y;
  logic [7:0]                  bg_index;

  // Raster and renderer side ports
  logic [`HCOUNT_WIDTH-1:0]    h_pos;
  logic [`VCOUNT_WIDTH-1:0]    v_pos;
  logic                        active;
  logic                        hsync;
  logic                        vsync;
  logic [`MAP_ADDR_WIDTH-1:0]  ren_map_addr;
  mpu_data_t                   ren_map_data;
  logic [`VRAM_ADDR_WIDTH-1:0] ren_vram_addr;
  mpu_data_t                   ren_vram_data;
  logic [`PAL_ADDR_WIDTH-1:0]  ren_pal_addr;
  logic [`PAL_BYTES*8-1:0]     ren_pal_data;

  mpu_bus_decoder decoder (
    .clk, .rst, .mpu_en, .mpu_rd, .mpu_wr, .mpu_be, .mpu_addr, .mpu_data_in,
    .reg_rdata, .pal_rdata, .map_rdata, .vram_rdata,
    .reg_wr, .reg_rd, .reg_addr, .reg_be,
    .pal_wr, .pal_rd, .pal_addr, .pal_be, .pal_wdata,
    .map_wr, .map_rd, .map_addr, .map_be,
    .vram_wr, .vram_rd, .vram_addr, .vram_be,
    .mpu_data_out
  );

  main_registers registers (
    .clk, .rst, .wr(reg_wr), .rd(reg_rd), .addr(reg_addr), .be(reg_be),
    .data_in(mpu_data_in), .data_out(reg_rdata),
    .display_en, .scroll_x, .scroll_y, .bg_index
  );

  dual_port_ram #(.DATA_BYTES(`PAL_BYTES), .DEPTH(`PAL_LENGTH / 2)) palette (
    .clk, .wr_a(pal_wr), .rd_a(pal_rd), .addr_a(pal_addr), .be_a(pal_be),
    .data_in_a(pal_wdata), .data_out_a(pal_rdata),
    .addr_b(ren_pal_addr), .data_out_b(ren_pal_data)
  );

  dual_port_ram #(.DATA_BYTES(2), .DEPTH(`MAP_LENGTH)) tilemap (
    .clk, .wr_a(map_wr), .rd_a(map_rd), .addr_a(map_addr), .be_a(map_be),
    .data_in_a(mpu_data_in), .data_out_a(map_rdata),
    .addr_b(ren_map_addr), .data_out_b(ren_map_data)
  );

  dual_port_ram #(.DATA_BYTES(2), .DEPTH(`VRAM_LENGTH)) vram (
    .clk, .wr_a(vram_wr), .rd_a(vram_rd), .addr_a(vram_addr), .be_a(vram_be),
    .data_in_a(mpu_data_in), .data_out_a(vram_rdata),
    .addr_b(ren_vram_addr), .data_out_b(ren_vram_data)
  );

  display_timing timing (
    .clk, .rst, .h_pos, .v_pos, .active, .hsync, .vsync
  );

  tile_renderer renderer (
    .clk, .rst, .h_pos, .v_pos, .active, .hsync, .vsync,
    .display_en, .scroll_x, .scroll_y, .bg_index,
    .map_addr(ren_map_addr), .map_data(ren_map_data),
    .vram_addr(ren_vram_addr), .vram_data(ren_vram_data),
    .pal_addr(ren_pal_addr), .pal_data(ren_pal_data),
    .vga_hsync, .vga_vsync, .vga_de, .vga_rgb
  );

endmodule

// File: hdl/tile_renderer.sv
// Fixed four-cycle latency with no stalls; a map entry's low six bits select one of 64 tiles
`include "tile_gfx_consts.svh"

module tile_renderer import tile_gfx_pkg::*; (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`HCOUNT_WIDTH-1:0]    h_pos,
  input  logic [`VCOUNT_WIDTH-1:0]    v_pos,
  input  logic                        active,
  input  logic                        hsync,
  input  logic                        vsync,
  input  logic                        display_en,
  input  logic [`HCOUNT_WIDTH-1:0]    scroll_x,
  input  logic [`VCOUNT_WIDTH-1:0]    scroll_y,
  input  logic [7:0]                  bg_index,
  output logic [`MAP_ADDR_WIDTH-1:0]  map_addr,
  input  mpu_data_t                   map_data,
  output logic [`VRAM_ADDR_WIDTH-1:0] vram_addr,
  input  mpu_data_t                   vram_data,
  output logic [`PAL_ADDR_WIDTH-1:0]  pal_addr,
  input  logic [`PAL_BYTES*8-1:0]     pal_data,
  output logic                        vga_hsync,
  output logic                        vga_vsync,
  output logic                        vga_de,
  output rgb_t                        vga_rgb
);

  localparam int FINE_BITS = $clog2(`TILE_SIZE);
  localparam int LAST      = `RENDER_LATENCY - 1;

  // Per-stage control {display_en, vsync, hsync, active}
  logic [3:0] ctl_q [`RENDER_LATENCY];

  logic [`HCOUNT_WIDTH-1:0] scr_x;
  logic [`VCOUNT_WIDTH-1:0] scr_y;
  logic [FINE_BITS-1:0]     s1_fx;
  logic [FINE_BITS-1:0]     s1_fy;
  logic [FINE_BITS-1:0]     s2_fx;
  logic [FINE_BITS-1:0]     s2_fy;
  logic                     s3_fx0;
  logic                     s3_bg;
  logic [7:0]               s1_bg_index;
  logic [7:0]               s2_bg_index;
  logic [7:0]               s3_bg_index;
  logic                     map_bg;
  rgb_t                     pix_rgb;

  // Stage 1: scrolled position, wraps at 128 through the 7-bit sum
  assign scr_x = h_pos + scroll_x;
  assign scr_y = v_pos + scroll_y;

  always_ff @(posedge clk) begin
    map_addr    <= {scr_y[`VCOUNT_WIDTH-1:FINE_BITS], scr_x[`HCOUNT_WIDTH-1:FINE_BITS]};
    s1_fx       <= scr_x[FINE_BITS-1:0];
    s1_fy       <= scr_y[FINE_BITS-1:0];
    s1_bg_index <= bg_index;
    // Stage 2 side data, waiting on the map read
    s2_fx       <= s1_fx;
    s2_fy       <= s1_fy;
    s2_bg_index <= s1_bg_index;
    // Stage 3 side data, waiting on the VRAM read
    s3_fx0      <= s2_fx[0];
    s3_bg       <= map_bg;
    s3_bg_index <= s2_bg_index;
  end

  // Stage 2: 32 words per tile, 4 words per row, two pixels per word
  assign map_bg    = (map_data == 16'hFFFF);
  assign vram_addr = {map_data[5:0], s2_fy, s2_fx[FINE_BITS-1:1]};

  // Stage 3: left pixel sits in the low byte
  assign pal_addr = s3_bg  ? s3_bg_index :
                    s3_fx0 ? vram_data[15:8] : vram_data[7:0];

  // Stage 4: upper six bits of each channel byte
  assign pix_rgb = {pal_data[7:2], pal_data[15:10], pal_data[23:18]};

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RENDER_LATENCY; i++)
        ctl_q[i] <= '0;
      vga_de    <= 1'b0;
      vga_hsync <= 1'b0;
      vga_vsync <= 1'b0;
      vga_rgb   <= '0;
    end else begin
      ctl_q[0] <= {display_en, vsync, hsync, active};
      for (int i = 1; i < `RENDER_LATENCY; i++)
        ctl_q[i] <= ctl_q[i-1];
      vga_de    <= ctl_q[LAST][0];
      vga_hsync <= ctl_q[LAST][1];
      vga_vsync <= ctl_q[LAST][2];
      vga_rgb   <= (ctl_q[LAST][0] && ctl_q[LAST][3]) ? pix_rgb : '0;  // Blank or disabled
    end
  end

endmodule

// File: hdl/mpu_bus_decoder.sv
// Unmapped addresses drop writes and read zero; a read sampled on one edge is returned after the next
`include "tile_gfx_consts.svh"

module mpu_bus_decoder import tile_gfx_pkg::*; (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        mpu_en,
  input  logic                        mpu_rd,
  input  logic                        mpu_wr,
  input  logic [1:0]                  mpu_be,
  input  mpu_addr_t                   mpu_addr,
  input  mpu_data_t                   mpu_data_in,
  input  mpu_data_t                   reg_rdata,
  input  logic [`PAL_BYTES*8-1:0]     pal_rdata,
  input  mpu_data_t                   map_rdata,
  input  mpu_data_t                   vram_rdata,
  output logic                        reg_wr,
  output logic                        reg_rd,
  output logic [`REG_ADDR_WIDTH-1:0]  reg_addr,
  output logic [1:0]                  reg_be,
  output logic                        pal_wr,
  output logic                        pal_rd,
  output logic [`PAL_ADDR_WIDTH-1:0]  pal_addr,
  output logic [`PAL_BYTES-1:0]       pal_be,
  output logic [`PAL_BYTES*8-1:0]     pal_wdata,
  output logic                        map_wr,
  output logic                        map_rd,
  output logic [`MAP_ADDR_WIDTH-1:0]  map_addr,
  output logic [1:0]                  map_be,
  output logic                        vram_wr,
  output logic                        vram_rd,
  output logic [`VRAM_ADDR_WIDTH-1:0] vram_addr,
  output logic [1:0]                  vram_be,
  output mpu_data_t                   mpu_data_out
);

  mpu_region_e region;
  mpu_region_e rd_region;   // Target of last cycle's read
  mpu_addr_t   offset;      // Address relative to the region base
  logic        wr_cycle;
  logic        rd_cycle;
  logic        rd_odd;
  mpu_data_t   rd_data;

  function automatic logic in_range(input mpu_addr_t addr, input int unsigned base,
                                    input int unsigned length);
    return (32'(addr) >= base) && (32'(addr) < base + length);
  endfunction

  always_comb begin
    region = region_none;
    offset = '0;
    if (in_range(mpu_addr, `REG_BASE, `NUM_MAIN_REGS)) begin
      region = region_reg;
      offset = mpu_addr - mpu_addr_t'(`REG_BASE);
    end else if (in_range(mpu_addr, `PAL_BASE, `PAL_LENGTH)) begin
      region = region_pal;
      offset = mpu_addr - mpu_addr_t'(`PAL_BASE);
    end else if (in_range(mpu_addr, `MAP_BASE, `MAP_LENGTH)) begin
      region = region_map;
      offset = mpu_addr - mpu_addr_t'(`MAP_BASE);
    end else if (in_range(mpu_addr, `VRAM_BASE, `VRAM_LENGTH)) begin
      region = region_vram;
      offset = mpu_addr - mpu_addr_t'(`VRAM_BASE);
    end
  end

  assign wr_cycle = mpu_en & mpu_wr;
  assign rd_cycle = mpu_en & mpu_rd;

  assign reg_wr   = wr_cycle & (region == region_reg);
  assign reg_rd   = rd_cycle & (region == region_reg);
  assign reg_addr = offset[`REG_ADDR_WIDTH-1:0];
  assign reg_be   = mpu_be;

  // Even word carries red and green, odd word carries blue in its low byte
  assign pal_wr    = wr_cycle & (region == region_pal);
  assign pal_rd    = rd_cycle & (region == region_pal);
  assign pal_addr  = offset[`PAL_ADDR_WIDTH:1];
  assign pal_be    = offset[0] ? {mpu_be[0], 2'b00} : {1'b0, mpu_be};
  assign pal_wdata = {mpu_data_in[7:0], mpu_data_in};

  assign map_wr   = wr_cycle & (region == region_map);
  assign map_rd   = rd_cycle & (region == region_map);
  assign map_addr = offset[`MAP_ADDR_WIDTH-1:0];
  assign map_be   = mpu_be;

  assign vram_wr   = wr_cycle & (region == region_vram);
  assign vram_rd   = rd_cycle & (region == region_vram);
  assign vram_addr = offset[`VRAM_ADDR_WIDTH-1:0];
  assign vram_be   = mpu_be;

  always_comb begin
    case (rd_region)
      region_reg:  rd_data = reg_rdata;
      region_pal:  rd_data = rd_odd ? {8'h00, pal_rdata[23:16]} : pal_rdata[15:0];
      region_map:  rd_data = map_rdata;
      region_vram: rd_data = vram_rdata;
      default:     rd_data = '0;    // No read issued
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_region    <= region_none;
      rd_odd       <= 1'b0;
      mpu_data_out <= '0;
    end else begin
      rd_region    <= rd_cycle ? region : region_none;
      rd_odd       <= offset[0];
      mpu_data_out <= rd_data;
    end
  end

endmodule

// File: hdl/dual_port_ram.sv
// Contents undefined at power-up; port A read data is zero on any cycle after rd_a was low
module dual_port_ram #(
  parameter int DATA_BYTES = 2,
  parameter int DEPTH      = 256
) (
  input  logic                     clk,
  input  logic                     wr_a,
  input  logic                     rd_a,
  input  logic [$clog2(DEPTH)-1:0] addr_a,
  input  logic [DATA_BYTES-1:0]    be_a,
  input  logic [DATA_BYTES*8-1:0]  data_in_a,
  output logic [DATA_BYTES*8-1:0]  data_out_a,
  input  logic [$clog2(DEPTH)-1:0] addr_b,
  output logic [DATA_BYTES*8-1:0]  data_out_b
);

  logic [DATA_BYTES*8-1:0] mem [DEPTH];

  // Port A, host side
  always_ff @(posedge clk) begin
    if (wr_a) begin
      for (int b = 0; b < DATA_BYTES; b++)
        if (be_a[b])
          mem[addr_a][b*8 +: 8] <= data_in_a[b*8 +: 8];
    end
    data_out_a <= rd_a ? mem[addr_a] : '0;
  end

  always_ff @(posedge clk)
    data_out_b <= mem[addr_b];  // Renderer side, read every cycle

endmodule

// File: hdl/main_registers.sv
// Four 16-bit control registers cleared by reset; read data appears one cycle after rd
`include "tile_gfx_consts.svh"

module main_registers import tile_gfx_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wr,
  input  logic                       rd,
  input  logic [`REG_ADDR_WIDTH-1:0] addr,
  input  logic [1:0]                 be,
  input  mpu_data_t                  data_in,
  output mpu_data_t                  data_out,
  output logic                       display_en,
  output logic [`HCOUNT_WIDTH-1:0]   scroll_x,
  output logic [`VCOUNT_WIDTH-1:0]   scroll_y,
  output logic [7:0]                 bg_index
);

  mpu_data_t regs [`NUM_MAIN_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_MAIN_REGS; i++)
        regs[i] <= '0;
      data_out <= '0;
    end else begin
      if (wr) begin
        // Byte lanes written independently
        for (int b = 0; b < 2; b++)
          if (be[b])
            regs[addr][b*8 +: 8] <= data_in[b*8 +: 8];
      end
      data_out <= rd ? regs[addr] : '0;  // Zero between reads
    end
  end

  // Fields seen by the renderer
  assign display_en = regs[`REG_CTRL][0];
  assign scroll_x   = regs[`REG_SCROLL_X][`HCOUNT_WIDTH-1:0];
  assign scroll_y   = regs[`REG_SCROLL_Y][`VCOUNT_WIDTH-1:0];
  assign bg_index   = regs[`REG_BG_INDEX][7:0];

endmodule

// File: hdl/display_timing.sv
// Counts start at the first active pixel after reset; hsync and vsync are active high
`include "tile_gfx_consts.svh"

module display_timing import tile_gfx_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  output logic [`HCOUNT_WIDTH-1:0] h_pos,
  output logic [`VCOUNT_WIDTH-1:0] v_pos,
  output logic                     active,
  output logic                     hsync,
  output logic                     vsync
);

  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;

  disp_phase_e h_phase;
  disp_phase_e v_phase;
  logic        line_end;

  // Phase of a count within one line or one frame
  function automatic disp_phase_e phase_of(input int count, input int act_len,
                                           input int front_len, input int sync_len);
    if (count < act_len)
      return phase_active;
    else if (count < act_len + front_len)
      return phase_front;
    else if (count < act_len + front_len + sync_len)
      return phase_sync;
    else
      return phase_back;
  endfunction

  assign line_end = (h_pos == H_TOTAL - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      h_pos <= '0;
      v_pos <= '0;
    end else if (line_end) begin
      h_pos <= '0;
      if (v_pos == V_TOTAL - 1)
        v_pos <= '0;             // Frame wrap
      else
        v_pos <= v_pos + 1'b1;
    end else begin
      h_pos <= h_pos + 1'b1;
    end
  end

  assign h_phase = phase_of(int'(h_pos), `H_ACTIVE, `H_FRONT, `H_SYNC);
  assign v_phase = phase_of(int'(v_pos), `V_ACTIVE, `V_FRONT, `V_SYNC);

  assign active = (h_phase == phase_active) && (v_phase == phase_active);
  assign hsync  = (h_phase == phase_sync);
  assign vsync  = (v_phase == phase_sync);

endmodule

// File: hdl/tile_gfx_pkg.sv
// Shared bus, pixel and decode types; their widths come from the constants header
`include "tile_gfx_consts.svh"

package tile_gfx_pkg;

  typedef logic [`MPU_ADDR_WIDTH-1:0] mpu_addr_t;
  typedef logic [`MPU_DATA_WIDTH-1:0] mpu_data_t;
  typedef logic [`RGB_DEPTH-1:0]      rgb_t;   // R in the top bits

  // Target of one bus access
  typedef enum logic [2:0] {
    region_none,
    region_reg,
    region_pal,
    region_map,
    region_vram
  } mpu_region_e;

  // Where a horizontal or vertical count sits
  typedef enum logic [1:0] {
    phase_active,
    phase_front,
    phase_sync,
    phase_back
  } disp_phase_e;

endpackage

// File: hdl/tile_gfx_consts.svh
// Reduced 64x48 raster for short simulations; bus bases are word addresses, palette entries span two words
`ifndef TILE_GFX_CONSTS_SVH
`define TILE_GFX_CONSTS_SVH

`define MPU_ADDR_WIDTH 16
`define MPU_DATA_WIDTH 16
`define RGB_DEPTH      18   // 6 bits each of red, green, blue

// Raster timing, one clock per pixel
`define H_ACTIVE 64
`define H_FRONT  4
`define H_SYNC   6
`define H_BACK   6
`define V_ACTIVE 48
`define V_FRONT  2
`define V_SYNC   2
`define V_BACK   4
`define HCOUNT_WIDTH 7
`define VCOUNT_WIDTH 7

`define TILE_SIZE 8
`define MAP_COLS  16
`define MAP_ROWS  16

// Memory map
`define REG_BASE      'h0000
`define NUM_MAIN_REGS 4
`define PAL_BASE      'h0100
`define PAL_LENGTH    512   // Two words per entry
`define MAP_BASE      'h1000
`define MAP_LENGTH    256
`define VRAM_BASE     'h4000
`define VRAM_LENGTH   2048  // 64 tiles of 32 words

// Local address widths behind the decoder
`define REG_ADDR_WIDTH  2
`define PAL_ADDR_WIDTH  8   // Palette entry, not bus word
`define PAL_BYTES       3
`define MAP_ADDR_WIDTH  8
`define VRAM_ADDR_WIDTH 11

// Register indices
`define REG_CTRL     0      // Bit 0 enables the display
`define REG_SCROLL_X 1
`define REG_SCROLL_Y 2
`define REG_BG_INDEX 3      // Used for map entries of 16'hFFFF

`define RENDER_LATENCY 4

`endif
